// File: design/max_pool_2x2.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_yolo_defs.svh"

module max_pool_2x2 (
    input  wire logic                aclk,
    input  wire logic                reset,
    input  wire tiny_yolo_pkg::pix_t win_tl,
    input  wire tiny_yolo_pkg::pix_t win_tr,
    input  wire tiny_yolo_pkg::pix_t win_bl,
    input  wire tiny_yolo_pkg::pix_t win_br,
    input  wire logic                win_valid,
    input  wire logic                win_last,
    output tiny_yolo_pkg::pool_t     pool_data,
    output logic                     pool_valid,
    output logic                     pool_last
);

    tiny_yolo_pkg::pool_t top_max_q;
    tiny_yolo_pkg::pool_t bot_max_q;
    logic                 s1_valid;
    logic                 s1_last;

    // negative pixels go to zero
    function automatic tiny_yolo_pkg::pool_t relu(input tiny_yolo_pkg::pix_t p);
        return p[`YOLO_PIX_WIDTH-1] ? '0 : tiny_yolo_pkg::pool_t'(p);
    endfunction

    function automatic tiny_yolo_pkg::pool_t max2(input tiny_yolo_pkg::pool_t a,
                                                  input tiny_yolo_pkg::pool_t b);
        return (a > b) ? a : b;
    endfunction

    // --------------------------------------------------------------------------
    // stage 1, relu and row maxima
    // --------------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        top_max_q <= max2(relu(win_tl), relu(win_tr));
        bot_max_q <= max2(relu(win_bl), relu(win_br));
    end

    // --------------------------------------------------------------------------
    // stage 2, window maximum
    // --------------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        pool_data <= max2(top_max_q, bot_max_q);
    end

    // flags ride along with the data
    always_ff @(posedge aclk) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            s1_last    <= 1'b0;
            pool_valid <= 1'b0;
            pool_last  <= 1'b0;
        end else begin
            s1_valid   <= win_valid;
            s1_last    <= win_valid && win_last;
            pool_valid <= s1_valid;
            pool_last  <= s1_last;
        end
    end

endmodule

`default_nettype wire

// File: design/pixel_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_yolo_defs.svh"

module pixel_line_buffer (
    input  wire logic                       aclk,
    input  wire logic                       reset,
    input  wire logic                       layer_start,
    input  wire logic                       layer_busy,
    input  wire logic [`YOLO_DIM_WIDTH-1:0] img_width,
    input  wire logic [`YOLO_DIM_WIDTH-1:0] img_height,
    input  wire tiny_yolo_pkg::pix_t        pix_data,
    input  wire logic                       pix_valid,
    output tiny_yolo_pkg::pix_t             win_tl,
    output tiny_yolo_pkg::pix_t             win_tr,
    output tiny_yolo_pkg::pix_t             win_bl,
    output tiny_yolo_pkg::pix_t             win_br,
    output logic                            win_valid,
    output logic                            win_last
);

    localparam int IDX_W = $clog2(`YOLO_MAX_WIDTH);

    tiny_yolo_pkg::pix_t        row_mem [`YOLO_MAX_WIDTH];
    tiny_yolo_pkg::pix_t        top_left_q;
    tiny_yolo_pkg::pix_t        bot_left_q;
    logic [`YOLO_DIM_WIDTH-1:0] col_q;
    logic [`YOLO_DIM_WIDTH-1:0] row_q;
    logic [IDX_W-1:0]           col_idx;
    logic                       accept;
    logic                       col_end;
    logic                       row_end;
    logic                       win_hit;

    assign accept  = pix_valid && layer_busy;
    assign col_idx = col_q[IDX_W-1:0];
    assign col_end = (col_q == img_width - 1'b1);
    assign row_end = (row_q == img_height - 1'b1);
    // bottom-right pixel of a window: odd row, odd column
    assign win_hit = accept && row_q[0] && col_q[0];

    // raster position
    always_ff @(posedge aclk) begin
        if (reset) begin
            col_q <= '0;
            row_q <= '0;
        end else if (layer_start) begin
            col_q <= '0;
            row_q <= '0;
        end else if (accept) begin
            if (col_end) begin
                col_q <= '0;
                row_q <= row_end ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // even rows fill the memory, odd rows park the left column
    always_ff @(posedge aclk) begin
        if (accept) begin
            if (!row_q[0]) begin
                row_mem[col_idx] <= pix_data;
            end else if (!col_q[0]) begin
                top_left_q <= row_mem[col_idx];
                bot_left_q <= pix_data;
            end
        end
    end

    // window pixels
    always_ff @(posedge aclk) begin
        if (win_hit) begin
            win_tl <= top_left_q;
            win_tr <= row_mem[col_idx];
            win_bl <= bot_left_q;
            win_br <= pix_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            win_valid <= win_hit;
            win_last  <= win_hit && row_end && col_end;
        end
    end

    assert property (@(posedge aclk) disable iff (reset)
        (accept && !row_q[0]) |=> !win_valid);

endmodule

`default_nettype wire

// File: design/pool_word_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_yolo_defs.svh"

module pool_word_packer (
    input  wire logic                 aclk,
    input  wire logic                 reset,
    input  wire logic                 layer_start,
    input  wire tiny_yolo_pkg::pool_t pool_data,
    input  wire logic                 pool_valid,
    input  wire logic                 pool_last,
    output tiny_yolo_pkg::out_word_t  out_word,
    output logic                      out_valid,
    output logic                      out_last,
    output logic                      layer_end
);

    localparam int CNT_W = $clog2(`YOLO_BYTES_PER_WORD);

    tiny_yolo_pkg::out_word_t word_q;
    tiny_yolo_pkg::out_word_t word_next;
    logic [CNT_W-1:0]         byte_cnt;
    logic                     emit;

    // lowest byte first, unfilled bytes stay zero
    assign word_next = word_q | (tiny_yolo_pkg::out_word_t'(pool_data) << {byte_cnt, 3'b000});
    assign emit      = pool_valid && ((byte_cnt == CNT_W'(`YOLO_BYTES_PER_WORD - 1)) || pool_last);

    always_ff @(posedge aclk) begin
        if (reset || layer_start) begin
            byte_cnt <= '0;
            word_q   <= '0;
        end else if (emit) begin
            byte_cnt <= '0;
            word_q   <= '0;
        end else if (pool_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
            word_q   <= word_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (emit) begin
            out_word <= word_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= emit;
            out_last  <= pool_valid && pool_last;
        end
    end

    // final word closes the layer
    assign layer_end = out_last;

    assert property (@(posedge aclk) disable iff (reset) out_last |-> out_valid);

endmodule

`default_nettype wire

// File: design/tiny_yolo.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_yolo_defs.svh"

module tiny_yolo (
    input  wire logic                       aclk,
    input  wire logic                       reset,
    input  wire logic                       reg_wr_en,
    input  wire logic                       reg_rd_en,
    input  wire tiny_yolo_pkg::reg_addr_e   reg_addr,
    input  wire tiny_yolo_pkg::reg_data_t   reg_wdata,
    output tiny_yolo_pkg::reg_data_t        reg_rdata,
    input  wire tiny_yolo_pkg::pix_t        pix_data,
    input  wire logic                       pix_valid,
    output tiny_yolo_pkg::out_word_t        out_word,
    output logic                            out_valid,
    output logic                            out_last
);

    // --------------------------------------------------------------------------
    // internal wires
    // --------------------------------------------------------------------------
    logic                       layer_start;
    logic                       layer_busy;
    logic                       layer_end;
    logic [`YOLO_DIM_WIDTH-1:0] img_width;
    logic [`YOLO_DIM_WIDTH-1:0] img_height;

    // window stream
    tiny_yolo_pkg::pix_t        win_tl;
    tiny_yolo_pkg::pix_t        win_tr;
    tiny_yolo_pkg::pix_t        win_bl;
    tiny_yolo_pkg::pix_t        win_br;
    logic                       win_valid;
    logic                       win_last;

    // pooled byte stream
    tiny_yolo_pkg::pool_t       pool_data;
    logic                       pool_valid;
    logic                       pool_last;

    yolo_cfg_regs u_yolo_cfg_regs (
        .aclk        (aclk),
        .reset       (reset),
        .reg_wr_en   (reg_wr_en),
        .reg_rd_en   (reg_rd_en),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .layer_end   (layer_end),
        .layer_start (layer_start),
        .layer_busy  (layer_busy),
        .img_width   (img_width),
        .img_height  (img_height)
    );

    pixel_line_buffer u_pixel_line_buffer (
        .aclk        (aclk),
        .reset       (reset),
        .layer_start (layer_start),
        .layer_busy  (layer_busy),
        .img_width   (img_width),
        .img_height  (img_height),
        .pix_data    (pix_data),
        .pix_valid   (pix_valid),
        .win_tl      (win_tl),
        .win_tr      (win_tr),
        .win_bl      (win_bl),
        .win_br      (win_br),
        .win_valid   (win_valid),
        .win_last    (win_last)
    );

    max_pool_2x2 u_max_pool_2x2 (
        .aclk        (aclk),
        .reset       (reset),
        .win_tl      (win_tl),
        .win_tr      (win_tr),
        .win_bl      (win_bl),
        .win_br      (win_br),
        .win_valid   (win_valid),
        .win_last    (win_last),
        .pool_data   (pool_data),
        .pool_valid  (pool_valid),
        .pool_last   (pool_last)
    );

    pool_word_packer u_pool_word_packer (
        .aclk        (aclk),
        .reset       (reset),
        .layer_start (layer_start),
        .pool_data   (pool_data),
        .pool_valid  (pool_valid),
        .pool_last   (pool_last),
        .out_word    (out_word),
        .out_valid   (out_valid),
        .out_last    (out_last),
        .layer_end   (layer_end)
    );

endmodule

`default_nettype wire

// File: design/tiny_yolo_defs.svh
`ifndef TINY_YOLO_DEFS_SVH
`define TINY_YOLO_DEFS_SVH

// --------------------------------------------------------------------------
// datapath widths
// --------------------------------------------------------------------------
`define YOLO_PIX_WIDTH          8
`define YOLO_WORD_WIDTH         64
`define YOLO_BYTES_PER_WORD     8

// register bus
`define YOLO_REG_WIDTH          32
`define YOLO_REG_ADDR_WIDTH     3

// image geometry, longest row held in the line buffer
`define YOLO_MAX_WIDTH          64
`define YOLO_DIM_WIDTH          7

// --------------------------------------------------------------------------
// register map
// --------------------------------------------------------------------------
`define YOLO_ADDR_CTRL          3'd0
`define YOLO_ADDR_WIDTH         3'd1
`define YOLO_ADDR_HEIGHT        3'd2
`define YOLO_ADDR_STATUS        3'd3

`endif

// File: design/tiny_yolo_pkg.sv
`default_nettype none

`include "tiny_yolo_defs.svh"

package tiny_yolo_pkg;

    // stream data
    typedef logic signed [`YOLO_PIX_WIDTH-1:0] pix_t;
    typedef logic [`YOLO_PIX_WIDTH-1:0] pool_t;
    typedef logic [`YOLO_WORD_WIDTH-1:0] out_word_t;

    // register access
    typedef logic [`YOLO_REG_WIDTH-1:0] reg_data_t;

    typedef enum logic [`YOLO_REG_ADDR_WIDTH-1:0] {
        REG_CTRL   = `YOLO_ADDR_CTRL,
        REG_WIDTH  = `YOLO_ADDR_WIDTH,
        REG_HEIGHT = `YOLO_ADDR_HEIGHT,
        REG_STATUS = `YOLO_ADDR_STATUS
    } reg_addr_e;

    // layer sequencing
    typedef enum logic [1:0] {
        LAYER_IDLE,
        LAYER_BUSY,
        LAYER_DONE
    } layer_state_e;

endpackage

`default_nettype wire

// File: design/yolo_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_yolo_defs.svh"

module yolo_cfg_regs (
    input  wire logic                       aclk,
    input  wire logic                       reset,
    input  wire logic                       reg_wr_en,
    input  wire logic                       reg_rd_en,
    input  wire tiny_yolo_pkg::reg_addr_e   reg_addr,
    input  wire tiny_yolo_pkg::reg_data_t   reg_wdata,
    output tiny_yolo_pkg::reg_data_t        reg_rdata,
    input  wire logic                       layer_end,
    output logic                            layer_start,
    output logic                            layer_busy,
    output logic [`YOLO_DIM_WIDTH-1:0]      img_width,
    output logic [`YOLO_DIM_WIDTH-1:0]      img_height
);

    tiny_yolo_pkg::layer_state_e state_q;
    logic                        start_req;
    logic                        layer_done;

    // start bit written to CTRL, only honoured outside a running layer
    assign start_req   = reg_wr_en && (reg_addr == tiny_yolo_pkg::REG_CTRL) && reg_wdata[0];
    assign layer_start = start_req && (state_q != tiny_yolo_pkg::LAYER_BUSY);
    assign layer_busy  = (state_q == tiny_yolo_pkg::LAYER_BUSY);
    assign layer_done  = (state_q == tiny_yolo_pkg::LAYER_DONE);

    // --------------------------------------------------------------------------
    // layer FSM
    // --------------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            state_q <= tiny_yolo_pkg::LAYER_IDLE;
        end else begin
            case (state_q)
                tiny_yolo_pkg::LAYER_BUSY: begin
                    if (layer_end) begin
                        state_q <= tiny_yolo_pkg::LAYER_DONE;
                    end
                end
                // idle or done, wait for the next start
                default: begin
                    if (layer_start) begin
                        state_q <= tiny_yolo_pkg::LAYER_BUSY;
                    end
                end
            endcase
        end
    end

    // image size registers
    always_ff @(posedge aclk) begin
        if (reset) begin
            img_width  <= '0;
            img_height <= '0;
        end else if (reg_wr_en) begin
            if (reg_addr == tiny_yolo_pkg::REG_WIDTH) begin
                img_width <= reg_wdata[`YOLO_DIM_WIDTH-1:0];
            end
            if (reg_addr == tiny_yolo_pkg::REG_HEIGHT) begin
                img_height <= reg_wdata[`YOLO_DIM_WIDTH-1:0];
            end
        end
    end

    // registered read port, holds until the next strobe
    always_ff @(posedge aclk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else if (reg_rd_en) begin
            case (reg_addr)
                tiny_yolo_pkg::REG_WIDTH:  reg_rdata <= tiny_yolo_pkg::reg_data_t'(img_width);
                tiny_yolo_pkg::REG_HEIGHT: reg_rdata <= tiny_yolo_pkg::reg_data_t'(img_height);
                tiny_yolo_pkg::REG_STATUS: begin
                    reg_rdata <= tiny_yolo_pkg::reg_data_t'({layer_done, layer_busy});
                end
                default:                   reg_rdata <= '0;
            endcase
        end
    end

    // the packer only closes a layer that was started here
    assert property (@(posedge aclk) disable iff (reset)
        layer_end |-> (state_q == tiny_yolo_pkg::LAYER_BUSY));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the tiny_yolo testbench with Verilator.
# The exit status is the simulator's own.

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv \
    --top-module tb_tiny_yolo \
    -f tiny_yolo.f \
    -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/Vtb_tiny_yolo
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit "$sim_status"
fi

echo "simulation finished with status 0"
exit 0

// File: tiny_yolo.f
+incdir+design
design/tiny_yolo_pkg.sv
design/yolo_cfg_regs.sv
design/pixel_line_buffer.sv
design/max_pool_2x2.sv
design/pool_word_packer.sv
design/tiny_yolo.sv
verif/tb_tiny_yolo.sv

// File: verif/tb_tiny_yolo.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_yolo_defs.svh"

module tb_tiny_yolo;

    localparam int NUM_CASES  = 5;
    localparam int CLK_HALF   = 20;
    localparam int WORD_WAIT  = 64;

    logic                       aclk;
    logic                       reset;
    logic                       reg_wr_en;
    logic                       reg_rd_en;
    tiny_yolo_pkg::reg_addr_e   reg_addr;
    tiny_yolo_pkg::reg_data_t   reg_wdata;
    tiny_yolo_pkg::reg_data_t   reg_rdata;
    tiny_yolo_pkg::pix_t        pix_data;
    logic                       pix_valid;
    tiny_yolo_pkg::out_word_t   out_word;
    logic                       out_valid;
    logic                       out_last;

    // case table: width, height, idle gaps, stray pixels plus a restart while busy
    int case_w     [NUM_CASES] = '{4, 8, 16, 64, 6};
    int case_h     [NUM_CASES] = '{2, 4, 6, 2, 4};
    int case_gap   [NUM_CASES] = '{0, 1, 0, 1, 1};
    int case_stray [NUM_CASES] = '{0, 0, 1, 0, 1};

    logic [31:0]                rng;
    tiny_yolo_pkg::pix_t        pixels [$];
    // expected words of all layers, in arrival order
    tiny_yolo_pkg::out_word_t   exp_words [$];
    logic                       exp_lasts [$];
    int                         next_word;

    tiny_yolo i_tiny_yolo (
        .aclk      (aclk),
        .reset     (reset),
        .reg_wr_en (reg_wr_en),
        .reg_rd_en (reg_rd_en),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .pix_data  (pix_data),
        .pix_valid (pix_valid),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_HALF) aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    // --------------------------------------------------------------------------
    // compare tasks
    // --------------------------------------------------------------------------
    task automatic check_word(input tiny_yolo_pkg::out_word_t exp_word,
                              input tiny_yolo_pkg::out_word_t act_word,
                              input logic exp_last,
                              input logic act_last);
        if (act_word !== exp_word) begin
            fail_now($sformatf("mismatch out_word: expected 0x%h, actual 0x%h",
                               exp_word, act_word));
        end
        if (act_last !== exp_last) begin
            fail_now($sformatf("mismatch out_last: expected 0x%h, actual 0x%h",
                               exp_last, act_last));
        end
    endtask

    task automatic check_reg(input string name,
                             input tiny_yolo_pkg::reg_data_t exp_data,
                             input tiny_yolo_pkg::reg_data_t act_data);
        if (act_data !== exp_data) begin
            fail_now($sformatf("mismatch %s: expected 0x%h, actual 0x%h",
                               name, exp_data, act_data));
        end
    endtask

    // register bus
    task automatic write_reg(input tiny_yolo_pkg::reg_addr_e addr,
                             input tiny_yolo_pkg::reg_data_t data);
        @(posedge aclk);
        reg_wr_en <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge aclk);
        reg_wr_en <= 1'b0;
    endtask

    // read data is registered, sampled mid-cycle after the strobe
    task automatic read_reg(input tiny_yolo_pkg::reg_addr_e addr,
                            output tiny_yolo_pkg::reg_data_t data);
        @(posedge aclk);
        reg_rd_en <= 1'b1;
        reg_addr  <= addr;
        @(posedge aclk);
        reg_rd_en <= 1'b0;
        @(negedge aclk);
        data = reg_rdata;
    endtask

    // --------------------------------------------------------------------------
    // reference model
    // --------------------------------------------------------------------------
    task automatic build_expected(input int w, input int h);
        tiny_yolo_pkg::out_word_t word;
        int r;
        int c;
        int k;
        int v;
        int best;
        int nbytes;
        int idx [4];
        pixels.delete();
        for (k = 0; k < w * h; k++) begin
            rng = xorshift32(rng);
            pixels.push_back(tiny_yolo_pkg::pix_t'(rng[15:8]));
        end
        word   = '0;
        nbytes = 0;
        for (r = 0; r < h; r += 2) begin
            for (c = 0; c < w; c += 2) begin
                idx[0] = r * w + c;
                idx[1] = idx[0] + 1;
                idx[2] = idx[0] + w;
                idx[3] = idx[2] + 1;
                // starting at zero folds the relu into the max
                best = 0;
                for (k = 0; k < 4; k++) begin
                    v = int'(pixels[idx[k]]);
                    if (v > best) begin
                        best = v;
                    end
                end
                word = word | (tiny_yolo_pkg::out_word_t'(tiny_yolo_pkg::pool_t'(best))
                               << (8 * nbytes));
                nbytes++;
                if (nbytes == `YOLO_BYTES_PER_WORD) begin
                    exp_words.push_back(word);
                    exp_lasts.push_back(1'b0);
                    word   = '0;
                    nbytes = 0;
                end
            end
        end
        // partial final word keeps its zero padding
        if (nbytes != 0) begin
            exp_words.push_back(word);
            exp_lasts.push_back(1'b0);
        end
        exp_lasts[exp_lasts.size() - 1] = 1'b1;
    endtask

    // --------------------------------------------------------------------------
    // stimulus
    // --------------------------------------------------------------------------
    task automatic drive_stray_pixels(input int count);
        int k;
        for (k = 0; k < count; k++) begin
            @(posedge aclk);
            rng = xorshift32(rng);
            pix_valid <= 1'b1;
            pix_data  <= tiny_yolo_pkg::pix_t'(rng[7:0]);
        end
        @(posedge aclk);
        pix_valid <= 1'b0;
    endtask

    task automatic drive_pixels(input int w, input int h, input int gap, input int restart);
        int   idx;
        int   total;
        int   cycles;
        logic restart_done;
        idx          = 0;
        total        = w * h;
        cycles       = 0;
        restart_done = 1'b0;
        while (idx < total) begin
            @(posedge aclk);
            rng = xorshift32(rng);
            reg_wr_en <= 1'b0;
            // start write in mid layer must be ignored
            if (restart != 0 && !restart_done && idx == total / 2) begin
                reg_wr_en    <= 1'b1;
                reg_addr     <= tiny_yolo_pkg::REG_CTRL;
                reg_wdata    <= 32'h1;
                restart_done = 1'b1;
            end
            if (gap != 0 && rng[1:0] == 2'd0) begin
                pix_valid <= 1'b0;
                pix_data  <= tiny_yolo_pkg::pix_t'(rng[23:16]);
            end else begin
                pix_valid <= 1'b1;
                pix_data  <= pixels[idx];
                idx++;
            end
            cycles++;
            if (cycles > 4 * total + 16) begin
                fail_now("timeout while driving the pixels of a layer");
            end
        end
        @(posedge aclk);
        pix_valid <= 1'b0;
        reg_wr_en <= 1'b0;
    endtask

    task automatic wait_for_words(input int limit);
        int cycles;
        cycles = 0;
        while (next_word != exp_words.size()) begin
            @(posedge aclk);
            cycles++;
            if (cycles > limit) begin
                fail_now("timeout waiting for the output words of a layer");
            end
        end
    endtask

    // output monitor, every word must be expected
    always @(negedge aclk) begin
        if (!reset) begin
            if (out_last && !out_valid) begin
                fail_now("out_last was raised without out_valid");
            end
            if (out_valid) begin
                if (next_word >= exp_words.size()) begin
                    fail_now("out_valid was raised while no word was expected");
                end else begin
                    check_word(exp_words[next_word], out_word,
                               exp_lasts[next_word], out_last);
                    next_word <= next_word + 1;
                end
            end
        end
    end

    initial begin
        tiny_yolo_pkg::reg_data_t rd;
        int ci;
        rng       = 32'hb18bcf87;
        next_word = 0;
        reset     <= 1'b1;
        reg_wr_en <= 1'b0;
        reg_rd_en <= 1'b0;
        reg_addr  <= tiny_yolo_pkg::REG_CTRL;
        reg_wdata <= '0;
        pix_data  <= '0;
        pix_valid <= 1'b0;
        repeat (2) @(posedge aclk);
        reset <= 1'b0;

        read_reg(tiny_yolo_pkg::REG_STATUS, rd);
        check_reg("reg_rdata", 32'h0, rd);
        repeat (4) @(posedge aclk);

        for (ci = 0; ci < NUM_CASES; ci++) begin
            write_reg(tiny_yolo_pkg::REG_WIDTH, tiny_yolo_pkg::reg_data_t'(case_w[ci]));
            write_reg(tiny_yolo_pkg::REG_HEIGHT, tiny_yolo_pkg::reg_data_t'(case_h[ci]));
            read_reg(tiny_yolo_pkg::REG_WIDTH, rd);
            check_reg("reg_rdata", tiny_yolo_pkg::reg_data_t'(case_w[ci]), rd);
            read_reg(tiny_yolo_pkg::REG_HEIGHT, rd);
            check_reg("reg_rdata", tiny_yolo_pkg::reg_data_t'(case_h[ci]), rd);
            // a whole frame of strays, enough to reach the output if accepted
            if (case_stray[ci] != 0) begin
                drive_stray_pixels(case_w[ci] * case_h[ci]);
            end
            build_expected(case_w[ci], case_h[ci]);

            write_reg(tiny_yolo_pkg::REG_CTRL, 32'h1);
            read_reg(tiny_yolo_pkg::REG_STATUS, rd);
            check_reg("reg_rdata", 32'h1, rd);

            drive_pixels(case_w[ci], case_h[ci], case_gap[ci], case_stray[ci]);
            wait_for_words(WORD_WAIT);
            read_reg(tiny_yolo_pkg::REG_STATUS, rd);
            check_reg("reg_rdata", 32'h2, rd);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
